/* Makefile */
VERILATOR  ?= verilator
TOP        := baser_257b_checker_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* include/baser_ref_model.svh */
`ifndef BASER_REF_MODEL_SVH
`define BASER_REF_MODEL_SVH

// Type restore by search over the known codes
function automatic logic [7:0] ref_restore(input logic [3:0] nib);
    logic [7:0] known [11] = '{baser_pkg::BT_C8, baser_pkg::BT_S0, baser_pkg::BT_O0,
                               baser_pkg::BT_T0, baser_pkg::BT_T1, baser_pkg::BT_T2,
                               baser_pkg::BT_T3, baser_pkg::BT_T4, baser_pkg::BT_T5,
                               baser_pkg::BT_T6, baser_pkg::BT_T7};
    foreach (known[i]) begin
        if (known[i][3:0] == nib) begin
            return known[i];
        end
    end
    return baser_pkg::BT_NONE;
endfunction

// Expected body for a control type, returns 0 when the type is unknown
function automatic logic ref_ctrl_body(input logic [7:0] btype, input logic [7:0] dc,
                                       input logic [6:0] cc, input logic [3:0] oc,
                                       output logic [55:0] body);
    logic [7:0] terms [7] = '{baser_pkg::BT_T0, baser_pkg::BT_T1, baser_pkg::BT_T2,
                              baser_pkg::BT_T3, baser_pkg::BT_T4, baser_pkg::BT_T5,
                              baser_pkg::BT_T6};
    int n;
    body = '0;
    n    = -1;
    if (btype == baser_pkg::BT_C8) begin
        body = {8{cc}};
        return 1'b1;
    end
    if (btype == baser_pkg::BT_S0 || btype == baser_pkg::BT_T7) begin
        body = {7{dc}};
        return 1'b1;
    end
    if (btype == baser_pkg::BT_O0) begin
        body = {28'd0, oc, {3{dc}}};
        return 1'b1;
    end
    foreach (terms[i]) begin
        if (btype == terms[i]) begin
            n = i;
        end
    end
    if (n < 0) begin
        return 1'b0;
    end
    // Characters placed one at a time, low bits first
    for (int i = 0; i < n; i++) begin
        body[8*i +: 8] = dc;
    end
    for (int j = 0; j < 7 - n; j++) begin
        body[7*n + 7 + 7*j +: 7] = cc;
    end
    return 1'b1;
endfunction

// Valid transcoded block, mask bit k set means lane k is data
function automatic logic [256:0] ref_build(input logic [3:0] mask, input logic [7:0] types [4],
                                           input logic [7:0] dc, input logic [6:0] cc,
                                           input logic [3:0] oc);
    logic [260:0] xc;
    logic [55:0]  body;
    logic         seen;
    xc   = '0;
    seen = 1'b0;
    if (mask == 4'hF) begin
        xc[0]     = 1'b1;
        xc[256:1] = {32{dc}};
        return xc[256:0];
    end
    xc[4:1] = mask;
    for (int k = 0; k < 4; k++) begin
        void'(ref_ctrl_body(types[k], dc, cc, oc, body));
        if (mask[k]) begin
            if (seen) begin
                xc[1 + 64*k +: 64] = {8{dc}};
            end else begin
                xc[5 + 64*k +: 64] = {8{dc}};
            end
        end else if (!seen) begin
            xc[5 + 64*k +: 4]  = types[k][3:0];
            xc[9 + 64*k +: 56] = body;
            seen               = 1'b1;
        end else begin
            xc[1 + 64*k +: 64] = {body, types[k]};
        end
    end
    return xc[256:0];
endfunction

// Lane flags and restored words, returns the format error
function automatic logic ref_lanes(input logic [256:0] xc, output logic [3:0] is_data,
                                   output logic [63:0] words [4]);
    logic [260:0] ext;
    logic         seen;
    ext  = {4'd0, xc};
    seen = 1'b0;
    for (int k = 0; k < 4; k++) begin
        if (xc[0] || seen) begin
            is_data[k] = xc[0] | xc[1 + k];
            words[k]   = ext[1 + 64*k +: 64];
        end else if (xc[1 + k]) begin
            is_data[k] = 1'b1;
            words[k]   = ext[5 + 64*k +: 64];
        end else begin
            is_data[k] = 1'b0;
            words[k]   = {ext[9 + 64*k +: 56], ref_restore(ext[5 + 64*k +: 4])};
            seen       = 1'b1;
        end
    end
    return !xc[0] && (&xc[4:1]);
endfunction

function automatic void ref_unpack(input logic [256:0] xc,
                                   output baser_pkg::coded_block_t coded [4]);
    logic [3:0]  is_data;
    logic [63:0] words [4];
    void'(ref_lanes(xc, is_data, words));
    for (int k = 0; k < 4; k++) begin
        coded[k].payload = words[k];
        coded[k].sh      = is_data[k] ? baser_pkg::SH_DATA : baser_pkg::SH_CTRL;
    end
endfunction

// Whole transcoded block counts as invalid once
function automatic logic ref_invalid(input logic [256:0] xc, input logic [7:0] dc,
                                     input logic [6:0] cc, input logic [3:0] oc);
    logic [3:0]  is_data;
    logic [63:0] words [4];
    logic [55:0] body;
    logic        bad;
    bad = ref_lanes(xc, is_data, words);
    for (int k = 0; k < 4; k++) begin
        if (is_data[k]) begin
            bad |= (words[k] != {8{dc}});
        end else if (!ref_ctrl_body(words[k][7:0], dc, cc, oc, body)) begin
            bad = 1'b1;
        end else begin
            bad |= (body != words[k][63:8]);
        end
    end
    return bad;
endfunction

`endif

/* dv/baser_257b_checker_tb.sv */
`timescale 1ns/10ps

module baser_257b_checker_tb;
    import baser_pkg::*;

    localparam logic [7:0] DATA_CHAR = 8'hAA;
    localparam logic [6:0] CTRL_CHAR = 7'h1E;
    localparam logic [3:0] OSET_CODE = 4'hF;
    localparam int         CNT_W     = 32;

    // Blocks sent in each phase
    localparam int N_DATA         = 20;
    localparam int N_MIXED        = 2 * LANES * 11;
    localparam int N_FLIP         = 50;
    localparam int N_NIBBLE       = 5 * LANES;
    localparam int N_FORMAT       = 5;
    localparam int N_RAND         = 400;
    localparam int STIM_CYCLES    = 3 + N_DATA + N_MIXED + N_FLIP + N_NIBBLE + N_FORMAT + N_RAND;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

    logic               clk;
    logic               i_rst;
    logic [XCODE_W-1:0] rx_xcoded;
    coded_block_t       rx_coded [LANES];
    logic [CNT_W-1:0]   block_count;
    logic [CNT_W-1:0]   data_count;
    logic [CNT_W-1:0]   ctrl_count;
    logic [CNT_W-1:0]   inv_count;

    integer seed;
    int     cycle_count = 0;

    // Expected state one cycle behind the input
    logic [XCODE_W-1:0] xc_sampled;
    logic               rst_sampled;
    coded_block_t       exp_coded [LANES];
    logic [CNT_W-1:0]   exp_block;
    logic [CNT_W-1:0]   exp_data;
    logic [CNT_W-1:0]   exp_ctrl;
    logic [CNT_W-1:0]   exp_inv;

    // Counter values when a phase starts
    logic [CNT_W-1:0] base_data;
    logic [CNT_W-1:0] base_ctrl;
    logic [CNT_W-1:0] base_inv;

    logic [7:0] ctrl_types [11] = '{BT_C8, BT_S0, BT_O0, BT_T0, BT_T1, BT_T2,
                                    BT_T3, BT_T4, BT_T5, BT_T6, BT_T7};
    logic [3:0] unused_nibbles [5] = '{4'h0, 4'h3, 4'h5, 4'h6, 4'hD};

    `include "baser_ref_model.svh"

    baser_257b_checker #(
        .DATA_CHAR (DATA_CHAR),
        .CTRL_CHAR (CTRL_CHAR),
        .OSET_CODE (OSET_CODE),
        .CNT_W     (CNT_W)
    ) uut (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_rx_xcoded       (rx_xcoded),
        .o_rx_coded        (rx_coded),
        .o_block_count     (block_count),
        .o_data_count      (data_count),
        .o_ctrl_count      (ctrl_count),
        .o_inv_block_count (inv_count)
    );

    always #4 clk = ~clk;

    function automatic logic [XCODE_W-1:0] rand_word();
        logic [287:0] w;
        for (int i = 0; i < 9; i++) begin
            w[32*i +: 32] = $random(seed);
        end
        return w[XCODE_W-1:0];
    endfunction

    // Lanes below pos are data and pos holds the first control block
    function automatic logic [XCODE_W-1:0] mixed_block(input int pos, input logic [7:0] first_type,
                                                       input logic rest_data);
        logic [3:0] mask;
        logic [7:0] types [4];
        int         r;
        for (int k = 0; k < LANES; k++) begin
            r        = $random(seed);
            types[k] = ctrl_types[r[7:0] % 11];
            mask[k]  = (k < pos) || ((k > pos) && (rest_data || r[8]));
        end
        types[pos] = first_type;
        return ref_build(mask, types, DATA_CHAR, CTRL_CHAR, OSET_CODE);
    endfunction

    task automatic check_equal(input string name, input logic [65:0] exp_val,
                               input logic [65:0] act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp_val, act_val);
            $display("CHECKS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic send_block(input logic [XCODE_W-1:0] xc);
        rx_xcoded = xc;
        @(negedge clk);
    endtask

    task automatic mark_counts();
        base_data = data_count;
        base_ctrl = ctrl_count;
        base_inv  = inv_count;
    endtask

    task automatic check_deltas(input string name, input int d_data, input int d_ctrl,
                                input int d_inv);
        check_equal({name, " data count rise"}, 66'(d_data), 66'(data_count - base_data));
        check_equal({name, " ctrl count rise"}, 66'(d_ctrl), 66'(ctrl_count - base_ctrl));
        check_equal({name, " invalid count rise"}, 66'(d_inv), 66'(inv_count - base_inv));
    endtask

    // Compare against the block sampled at this edge
    always @(posedge clk) begin
        xc_sampled  = rx_xcoded;
        rst_sampled = i_rst;
        #1;
        if (rst_sampled) begin
            for (int k = 0; k < LANES; k++) begin
                exp_coded[k] = '0;
            end
            exp_block = '0;
            exp_data  = '0;
            exp_ctrl  = '0;
            exp_inv   = '0;
        end else begin
            ref_unpack(xc_sampled, exp_coded);
            exp_block = exp_block + CNT_W'(1);
            if (xc_sampled[0]) begin
                exp_data = exp_data + CNT_W'(1);
            end else begin
                exp_ctrl = exp_ctrl + CNT_W'(1);
            end
            if (ref_invalid(xc_sampled, DATA_CHAR, CTRL_CHAR, OSET_CODE)) begin
                exp_inv = exp_inv + CNT_W'(1);
            end
        end
        for (int k = 0; k < LANES; k++) begin
            check_equal($sformatf("lane %0d coded block", k), exp_coded[k], rx_coded[k]);
        end
        check_equal("block count", 66'(exp_block), 66'(block_count));
        check_equal("data count", 66'(exp_data), 66'(data_count));
        check_equal("ctrl count", 66'(exp_ctrl), 66'(ctrl_count));
        check_equal("invalid count", 66'(exp_inv), 66'(inv_count));
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        logic [XCODE_W-1:0] xc;
        logic [7:0]         no_types [4];
        int                 bit_pos;
        int                 r;
        seed      = 32'h1218_af1e;
        clk       = 1'b0;
        i_rst     = 1'b1;
        rx_xcoded = '0;
        no_types  = '{BT_NONE, BT_NONE, BT_NONE, BT_NONE};

        repeat (3) @(negedge clk);
        i_rst = 1'b0;
        // Nothing counted until the first edge out of reset
        for (int k = 0; k < LANES; k++) begin
            check_equal("coded block after reset", 66'd0, rx_coded[k]);
        end
        check_equal("block count after reset", 66'd0, 66'(block_count));
        check_equal("invalid count after reset", 66'd0, 66'(inv_count));

        mark_counts();
        repeat (N_DATA) begin
            send_block(ref_build(4'hF, no_types, DATA_CHAR, CTRL_CHAR, OSET_CODE));
        end
        check_deltas("all data", N_DATA, 0, 0);

        // First round keeps lanes after the control lane as data
        mark_counts();
        for (int rnd = 0; rnd < 2; rnd++) begin
            for (int pos = 0; pos < LANES; pos++) begin
                for (int t = 0; t < 11; t++) begin
                    send_block(mixed_block(pos, ctrl_types[t], rnd == 0));
                end
            end
        end
        check_deltas("mixed", 0, N_MIXED, 0);

        // Single payload bit errors with flags and header untouched
        mark_counts();
        repeat (N_FLIP) begin
            r           = $random(seed);
            xc          = mixed_block(int'(r[1:0]), ctrl_types[r[15:8] % 11], r[16]);
            bit_pos     = 5 + int'($unsigned($random(seed)) % 252);
            xc[bit_pos] = ~xc[bit_pos];
            send_block(xc);
        end
        check_deltas("bit flip", 0, N_FLIP, N_FLIP);

        mark_counts();
        for (int pos = 0; pos < LANES; pos++) begin
            for (int u = 0; u < 5; u++) begin
                xc                    = mixed_block(pos, ctrl_types[u + 3], 1'b1);
                xc[5 + 64*pos +: 4]   = unused_nibbles[u];
                send_block(xc);
            end
        end
        check_deltas("unused nibble", 0, N_NIBBLE, N_NIBBLE);

        mark_counts();
        repeat (N_FORMAT) begin
            xc      = rand_word();
            xc[0]   = 1'b0;
            xc[4:1] = 4'hF;
            send_block(xc);
        end
        check_deltas("format error", 0, N_FORMAT, N_FORMAT);

        repeat (N_RAND) begin
            send_block(rand_word());
        end

        if (uut.u_counters.u_counter_assertions.fail_count != 0) begin
            $display("Counter assertions failed %0d times",
                     uut.u_counters.u_counter_assertions.fail_count);
            $display("CHECKS FAILED");
            $fatal(1, "Counter assertions failed");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* dv/baser_checker_assertions.sv */
`timescale 1ns/10ps

module baser_checker_assertions #(
    parameter int CNT_W = 32
) (
    input logic             clk,
    input logic             i_rst,
    input logic [CNT_W-1:0] i_block_count,
    input logic [CNT_W-1:0] i_data_count,
    input logic [CNT_W-1:0] i_ctrl_count,
    input logic [CNT_W-1:0] i_inv_block_count
);

    // Number of assertion failures seen so far
    int unsigned fail_count = 0;

    // Each counter moves by zero or one per edge
    a_block_step: assert property (@(posedge clk) disable iff (i_rst)
        CNT_W'(i_block_count - $past(i_block_count)) <= CNT_W'(1))
        else begin
            $error("block count stepped by more than one");
            fail_count++;
        end

    a_data_step: assert property (@(posedge clk) disable iff (i_rst)
        CNT_W'(i_data_count - $past(i_data_count)) <= CNT_W'(1))
        else begin
            $error("data count stepped by more than one");
            fail_count++;
        end

    a_ctrl_step: assert property (@(posedge clk) disable iff (i_rst)
        CNT_W'(i_ctrl_count - $past(i_ctrl_count)) <= CNT_W'(1))
        else begin
            $error("control count stepped by more than one");
            fail_count++;
        end

    a_inv_step: assert property (@(posedge clk) disable iff (i_rst)
        CNT_W'(i_inv_block_count - $past(i_inv_block_count)) <= CNT_W'(1))
        else begin
            $error("invalid count stepped by more than one");
            fail_count++;
        end

    // Every block is either all data or carries control
    a_split_sum: assert property (@(posedge clk) disable iff (i_rst)
        CNT_W'(i_data_count + i_ctrl_count) == i_block_count)
        else begin
            $error("data plus control count differs from block count");
            fail_count++;
        end

    a_inv_bound: assert property (@(posedge clk) disable iff (i_rst)
        i_inv_block_count <= i_block_count)
        else begin
            $error("invalid count exceeds block count");
            fail_count++;
        end

endmodule

bind baser_stats_counters baser_checker_assertions #(
    .CNT_W (CNT_W)
) u_counter_assertions (
    .clk               (clk),
    .i_rst             (i_rst),
    .i_block_count     (o_block_count),
    .i_data_count      (o_data_count),
    .i_ctrl_count      (o_ctrl_count),
    .i_inv_block_count (o_inv_block_count)
);

/* source/baser_257b_checker.sv */
`timescale 1ns/10ps

module baser_257b_checker #(
    parameter logic [7:0] DATA_CHAR = 8'hAA,
    parameter logic [6:0] CTRL_CHAR = 7'h1E,
    parameter logic [3:0] OSET_CODE = 4'hF,
    parameter int         CNT_W     = 32
) (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic [baser_pkg::XCODE_W-1:0] i_rx_xcoded,
    output baser_pkg::coded_block_t       o_rx_coded [baser_pkg::LANES],
    output logic [CNT_W-1:0]              o_block_count,
    output logic [CNT_W-1:0]              o_data_count,
    output logic [CNT_W-1:0]              o_ctrl_count,
    output logic [CNT_W-1:0]              o_inv_block_count
);
    import baser_pkg::*;

    lane_t            lanes [LANES];
    logic [LANES-1:0] lane_invalid;
    logic             format_err;

    baser_transcode_unpacker u_unpacker (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_rx_xcoded  (i_rx_xcoded),
        .o_lanes      (lanes),
        .o_format_err (format_err),
        .o_rx_coded   (o_rx_coded)
    );

    // One pattern checker per 64b lane
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        baser_block_checker #(
            .DATA_CHAR (DATA_CHAR),
            .CTRL_CHAR (CTRL_CHAR),
            .OSET_CODE (OSET_CODE)
        ) u_checker (
            .i_lane    (lanes[k]),
            .o_invalid (lane_invalid[k])
        );
    end

    baser_stats_counters #(
        .CNT_W (CNT_W)
    ) u_counters (
        .clk               (clk),
        .i_rst             (i_rst),
        .i_all_data        (i_rx_xcoded[0]),
        .i_lane_invalid    (lane_invalid),
        .i_format_err      (format_err),
        .o_block_count     (o_block_count),
        .o_data_count      (o_data_count),
        .o_ctrl_count      (o_ctrl_count),
        .o_inv_block_count (o_inv_block_count)
    );

endmodule

/* source/baser_block_checker.sv */
`timescale 1ns/10ps

module baser_block_checker #(
    parameter logic [7:0] DATA_CHAR = 8'hAA,
    parameter logic [6:0] CTRL_CHAR = 7'h1E,
    parameter logic [3:0] OSET_CODE = 4'hF
) (
    input  baser_pkg::lane_t i_lane,
    output logic             o_invalid
);
    import baser_pkg::*;

    localparam int BODY_W = BLOCK_W - 8;

    // Bodies filled with one kind of character from the low bits up
    localparam logic [BODY_W-1:0] DATA_BODY = {(BODY_W/8){DATA_CHAR}};
    localparam logic [BODY_W-1:0] CTRL_BODY = {(BODY_W/7){CTRL_CHAR}};

    block_word_t       word;
    logic [BODY_W-1:0] exp_body;
    logic              type_known;
    logic              data_bad;

    // Tn body: n data chars, 7-n zero bits, then 7-n control chars
    function automatic logic [BODY_W-1:0] term_body(input int unsigned n);
        logic [BODY_W-1:0] data_mask;
        data_mask = ({{(BODY_W-1){1'b0}}, 1'b1} << (8 * n)) - 1'b1;
        return (DATA_BODY & data_mask) | (CTRL_BODY << (7 * n + 7));
    endfunction

    assign word = i_lane.word;

    // Data lane, every byte must be the test data character
    always_comb begin
        data_bad = 1'b0;
        for (int i = 0; i < BLOCK_W/8; i++) begin
            if (word.data[i] != DATA_CHAR) begin
                data_bad = 1'b1;
            end
        end
    end

    // Control lane, expected body for the decoded type
    always_comb begin
        exp_body   = '0;
        type_known = 1'b1;
        case (word.ctrl.btype)
            BT_C8: begin
                exp_body = CTRL_BODY;
            end
            BT_S0, BT_T7: begin
                exp_body = DATA_BODY;
            end
            BT_O0: begin
                // Three data chars, the O code, then zeros
                exp_body = {28'd0, OSET_CODE, DATA_BODY[23:0]};
            end
            BT_T0: begin
                exp_body = term_body(0);
            end
            BT_T1: begin
                exp_body = term_body(1);
            end
            BT_T2: begin
                exp_body = term_body(2);
            end
            BT_T3: begin
                exp_body = term_body(3);
            end
            BT_T4: begin
                exp_body = term_body(4);
            end
            BT_T5: begin
                exp_body = term_body(5);
            end
            BT_T6: begin
                exp_body = term_body(6);
            end
            // BT_NONE and any unknown code land here
            default: begin
                type_known = 1'b0;
            end
        endcase
    end

    assign o_invalid = i_lane.is_data ? data_bad
                                      : (!type_known || (word.ctrl.body != exp_body));

endmodule

/* source/baser_pkg.sv */
package baser_pkg;

    // Transcoded block geometry
    localparam int LANES   = 4;
    localparam int BLOCK_W = 64;
    localparam int XCODE_W = 257;
    localparam int CODED_W = 66;

    // 66b sync headers, bit 1 is the data flag
    localparam logic [1:0] SH_DATA = 2'b10;
    localparam logic [1:0] SH_CTRL = 2'b01;

    // Block type field, one code per control block format
    localparam logic [7:0] BT_C8   = 8'h1E;
    localparam logic [7:0] BT_S0   = 8'h78;
    localparam logic [7:0] BT_O0   = 8'h4B;
    localparam logic [7:0] BT_T0   = 8'h87;
    localparam logic [7:0] BT_T1   = 8'h99;
    localparam logic [7:0] BT_T2   = 8'hAA;
    localparam logic [7:0] BT_T3   = 8'hB4;
    localparam logic [7:0] BT_T4   = 8'hCC;
    localparam logic [7:0] BT_T5   = 8'hD2;
    localparam logic [7:0] BT_T6   = 8'hE1;
    localparam logic [7:0] BT_T7   = 8'hFF;
    // Compressed type with no matching format
    localparam logic [7:0] BT_NONE = 8'h00;

    // One 64b block, seen as eight bytes or as type byte plus body
    typedef union packed {
        logic [BLOCK_W/8-1:0][7:0] data;
        struct packed {
            logic [BLOCK_W-9:0] body;
            logic [7:0]         btype;
        } ctrl;
    } block_word_t;

    typedef struct packed {
        logic        is_data;
        block_word_t word;
    } lane_t;

    typedef struct packed {
        logic [BLOCK_W-1:0]         payload;
        logic [CODED_W-BLOCK_W-1:0] sh;
    } coded_block_t;

endpackage

/* source/baser_stats_counters.sv */
`timescale 1ns/10ps

module baser_stats_counters #(
    parameter int CNT_W = 32
) (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic                        i_all_data,
    input  logic [baser_pkg::LANES-1:0] i_lane_invalid,
    input  logic                        i_format_err,
    output logic [CNT_W-1:0]            o_block_count,
    output logic [CNT_W-1:0]            o_data_count,
    output logic [CNT_W-1:0]            o_ctrl_count,
    output logic [CNT_W-1:0]            o_inv_block_count
);

    // One invalid count per transcoded block, however many lanes fail
    logic block_invalid;

    assign block_invalid = (|i_lane_invalid) || i_format_err;

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_block_count     <= '0;
            o_data_count      <= '0;
            o_ctrl_count      <= '0;
            o_inv_block_count <= '0;
        end else begin
            // A block arrives on every edge
            o_block_count <= o_block_count + CNT_W'(1);

            if (i_all_data) begin
                o_data_count <= o_data_count + CNT_W'(1);
            end else begin
                o_ctrl_count <= o_ctrl_count + CNT_W'(1);
            end

            if (block_invalid) begin
                o_inv_block_count <= o_inv_block_count + CNT_W'(1);
            end
        end
    end

endmodule

/* source/baser_transcode_unpacker.sv */
`timescale 1ns/10ps

module baser_transcode_unpacker (
    input  logic                          clk,
    input  logic                          i_rst,
    input  logic [baser_pkg::XCODE_W-1:0] i_rx_xcoded,
    output baser_pkg::lane_t              o_lanes [baser_pkg::LANES],
    output logic                          o_format_err,
    output baser_pkg::coded_block_t       o_rx_coded [baser_pkg::LANES]
);
    import baser_pkg::*;

    // Lane 3 placed after four flags would run past bit 256
    localparam int PAD_W = 4;
    localparam int EXT_W = XCODE_W + PAD_W;

    logic [EXT_W-1:0] xc_ext;
    logic             all_data;
    logic [LANES-1:0] flags;
    logic             seen_ctrl;

    // Full type from the low nibble kept for the first control block
    function automatic logic [7:0] restore_type(input logic [3:0] nib);
        case (nib)
            4'h1:    return BT_T6;
            4'h2:    return BT_T5;
            4'h4:    return BT_T3;
            4'h7:    return BT_T0;
            4'h8:    return BT_S0;
            4'h9:    return BT_T1;
            4'hA:    return BT_T2;
            4'hB:    return BT_O0;
            4'hC:    return BT_T4;
            4'hE:    return BT_C8;
            4'hF:    return BT_T7;
            default: return BT_NONE;
        endcase
    endfunction

    assign xc_ext   = {{PAD_W{1'b0}}, i_rx_xcoded};
    assign all_data = i_rx_xcoded[0];
    assign flags    = i_rx_xcoded[LANES:1];

    // All flags set needs the all-data header instead
    assign o_format_err = !all_data && (&flags);

    always_comb begin
        seen_ctrl = 1'b0;
        for (int k = 0; k < LANES; k++) begin
            if (all_data) begin
                o_lanes[k].is_data = 1'b1;
                o_lanes[k].word    = xc_ext[1 + BLOCK_W*k +: BLOCK_W];
            end else if (seen_ctrl) begin
                // Blocks after the first control block travel whole
                o_lanes[k].is_data = flags[k];
                o_lanes[k].word    = xc_ext[1 + BLOCK_W*k +: BLOCK_W];
            end else if (flags[k]) begin
                // Data ahead of the first control block, shifted past the flags
                o_lanes[k].is_data = 1'b1;
                o_lanes[k].word    = xc_ext[5 + BLOCK_W*k +: BLOCK_W];
            end else begin
                o_lanes[k].is_data         = 1'b0;
                o_lanes[k].word.ctrl.btype = restore_type(xc_ext[5 + BLOCK_W*k +: 4]);
                o_lanes[k].word.ctrl.body  = xc_ext[9 + BLOCK_W*k +: BLOCK_W-8];
                seen_ctrl                  = 1'b1;
            end
        end
    end

    // Rebuilt 66b blocks, one cycle behind the input
    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            for (int k = 0; k < LANES; k++) begin
                o_rx_coded[k] <= '0;
            end
        end else begin
            for (int k = 0; k < LANES; k++) begin
                o_rx_coded[k].payload <= o_lanes[k].word;
                o_rx_coded[k].sh      <= o_lanes[k].is_data ? SH_DATA : SH_CTRL;
            end
        end
    end

endmodule

/* sources.f */
+incdir+include
source/baser_pkg.sv
source/baser_transcode_unpacker.sv
source/baser_block_checker.sv
source/baser_stats_counters.sv
source/baser_257b_checker.sv
dv/baser_checker_assertions.sv
dv/baser_257b_checker_tb.sv
